/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

    // ------------------------------------------------------------------
    // instruction fields
    // ------------------------------------------------------------------

    localparam int REG_ADDR_W = 5;

    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000; // selects sub.

    // ------------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------------

    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_system = 7'b1110011
    } opcode_t;

    // op_halt covers EBREAK and every encoding the core does not run.
    typedef enum logic [2:0] {
        op_lui, op_alu, op_load, op_store, op_beq, op_bne, op_jal, op_halt
    } op_t;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt
    } alu_op_t;

endpackage

/* hdl/rv_bus_pkg.sv */
package rv_bus_pkg;

    localparam int XLEN = 32; // data and address width.

    // low address bits that are zero on every word access.
    localparam int WORD_ALIGN_BITS = 2;

    typedef enum logic [1:0] {
        req_none,
        req_fetch,
        req_data
    } requester_t;

endpackage

/* hdl/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode
(
    input  wire  [rv_bus_pkg::XLEN-1:0]       i_instr,
    output rv_isa_pkg::op_t                   o_op,
    output rv_isa_pkg::alu_op_t               o_alu_op,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] o_rd,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] o_rs1,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] o_rs2,
    output logic [rv_bus_pkg::XLEN-1:0]       o_imm,
    output logic                              o_use_imm
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = i_instr[rv_isa_pkg::FUNCT3_LSB +: 3];
    assign funct7 = i_instr[rv_isa_pkg::FUNCT7_LSB +: 7];

    assign o_rd  = i_instr[rv_isa_pkg::RD_LSB  +: rv_isa_pkg::REG_ADDR_W];
    assign o_rs1 = i_instr[rv_isa_pkg::RS1_LSB +: rv_isa_pkg::REG_ADDR_W];
    assign o_rs2 = i_instr[rv_isa_pkg::RS2_LSB +: rv_isa_pkg::REG_ADDR_W];

    always_comb
    begin
        o_op      = rv_isa_pkg::op_halt; // anything not matched below stops the core.
        o_alu_op  = rv_isa_pkg::alu_add;
        o_imm     = '0;
        o_use_imm = 1'b0;
        case (rv_isa_pkg::opcode_t'(i_instr[6:0]))
            rv_isa_pkg::opc_lui:
            begin
                o_op  = rv_isa_pkg::op_lui;
                o_imm = {i_instr[31:12], 12'b0};
            end
            rv_isa_pkg::opc_op_imm:
            begin
                if (funct3 == 3'b000) // addi is the only immediate form kept.
                begin
                    o_op      = rv_isa_pkg::op_alu;
                    o_use_imm = 1'b1;
                end
                o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
            end
            rv_isa_pkg::opc_op:
            begin
                if (funct7 == 7'b0)
                begin
                    o_op = rv_isa_pkg::op_alu;
                    case (funct3)
                        3'b000:  o_alu_op = rv_isa_pkg::alu_add;
                        3'b010:  o_alu_op = rv_isa_pkg::alu_slt;
                        3'b100:  o_alu_op = rv_isa_pkg::alu_xor;
                        3'b110:  o_alu_op = rv_isa_pkg::alu_or;
                        3'b111:  o_alu_op = rv_isa_pkg::alu_and;
                        default: o_op     = rv_isa_pkg::op_halt;
                    endcase
                end
                else if (funct7 == rv_isa_pkg::FUNCT7_ALT && funct3 == 3'b000)
                begin
                    o_op     = rv_isa_pkg::op_alu;
                    o_alu_op = rv_isa_pkg::alu_sub;
                end
            end
            rv_isa_pkg::opc_load:
            begin
                if (funct3 == 3'b010)
                    o_op = rv_isa_pkg::op_load;
                o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
            end
            rv_isa_pkg::opc_store:
            begin
                if (funct3 == 3'b010)
                    o_op = rv_isa_pkg::op_store;
                o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            end
            rv_isa_pkg::opc_branch:
            begin
                if (funct3 == 3'b000)
                    o_op = rv_isa_pkg::op_beq;
                else if (funct3 == 3'b001)
                    o_op = rv_isa_pkg::op_bne;
                o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                         i_instr[30:25], i_instr[11:8], 1'b0};
            end
            rv_isa_pkg::opc_jal:
            begin
                o_op  = rv_isa_pkg::op_jal;
                o_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                         i_instr[20], i_instr[30:21], 1'b0};
            end
            rv_isa_pkg::opc_system: o_op = rv_isa_pkg::op_halt; // ebreak.
            default: o_op = rv_isa_pkg::op_halt;
        endcase
    end

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile
(
    input  wire                                i_clk,
    input  wire                                i_reset,
    input  wire  [rv_isa_pkg::REG_ADDR_W-1:0]  i_rs1,
    input  wire  [rv_isa_pkg::REG_ADDR_W-1:0]  i_rs2,
    input  wire  [rv_isa_pkg::REG_ADDR_W-1:0]  i_rd,
    input  wire                                i_write,
    input  wire  [rv_bus_pkg::XLEN-1:0]        i_wdata,
    output logic [rv_bus_pkg::XLEN-1:0]        o_rdata1,
    output logic [rv_bus_pkg::XLEN-1:0]        o_rdata2
);

    logic [rv_bus_pkg::XLEN-1:0] regs [0:(1 << rv_isa_pkg::REG_ADDR_W)-1];

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < (1 << rv_isa_pkg::REG_ADDR_W); i++)
                regs[i] <= '0;
        end
        else if (i_write && i_rd != '0)
            regs[i_rd] <= i_wdata;
    end

    // x0 reads as zero whatever the array holds.
    assign o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

/* hdl/rv_fetch.sv */
`timescale 1ns/1ps

module rv_fetch
#(
    parameter logic [rv_bus_pkg::XLEN-1:0] RESET_ADDR = '0
)
(
    input  wire                         i_clk,
    input  wire                         i_reset,
    input  wire                         i_take,
    input  wire                         i_redirect,
    input  wire  [rv_bus_pkg::XLEN-1:0] i_target,
    input  wire                         i_halt,
    output logic [rv_bus_pkg::XLEN-1:0] o_instr,
    output logic [rv_bus_pkg::XLEN-1:0] o_pc,
    output logic                        o_instr_valid,
    output logic                        o_req,
    output logic [rv_bus_pkg::XLEN-1:0] o_addr,
    input  wire                         i_ack,
    input  wire  [rv_bus_pkg::XLEN-1:0] i_rdata
);

    logic [rv_bus_pkg::XLEN-1:0] next_pc;  // address of the next word to request.
    logic                        discard;  // the word in flight belongs to an old path.
    logic                        start;

    // a new request waits for an empty buffer and for the previous ack to drop.
    assign start = !o_req && !i_ack && !o_instr_valid && !i_halt && !i_redirect;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_req         <= 1'b0;
            o_instr_valid <= 1'b0;
            discard       <= 1'b0;
            next_pc       <= RESET_ADDR;
        end
        else
        begin
            if (o_req && i_ack)
            begin
                o_req   <= 1'b0;
                discard <= 1'b0;
                if (!discard && !i_redirect)
                begin
                    o_instr_valid <= 1'b1;
                    next_pc       <= o_addr + 4;
                end
            end
            if (i_take)
                o_instr_valid <= 1'b0;
            if (i_redirect)
            begin
                next_pc       <= i_target;
                o_instr_valid <= 1'b0;
                if (o_req && !i_ack)
                    discard <= 1'b1;
            end
            if (start)
                o_req <= 1'b1;
        end
    end

    // payload registers.
    always_ff @(posedge i_clk)
    begin
        if (start)
            o_addr <= next_pc;
        if (o_req && i_ack)
        begin
            o_instr <= i_rdata;
            o_pc    <= o_addr;
        end
    end

    // an ack only ever answers a request that is still up.
    assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_ack) |-> o_req);

endmodule

/* hdl/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute
(
    input  wire                                i_clk,
    input  wire                                i_reset,
    input  wire                                i_instr_valid,
    input  wire  [rv_bus_pkg::XLEN-1:0]        i_pc,
    input  rv_isa_pkg::op_t                    i_op,
    input  rv_isa_pkg::alu_op_t                i_alu_op,
    input  wire  [rv_isa_pkg::REG_ADDR_W-1:0]  i_rd,
    input  wire  [rv_bus_pkg::XLEN-1:0]        i_imm,
    input  wire                                i_use_imm,
    input  wire  [rv_bus_pkg::XLEN-1:0]        i_rdata1,
    input  wire  [rv_bus_pkg::XLEN-1:0]        i_rdata2,
    output logic                               o_take,
    output logic                               o_redirect,
    output logic [rv_bus_pkg::XLEN-1:0]        o_target,
    output logic                               o_reg_write,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]  o_rd,
    output logic [rv_bus_pkg::XLEN-1:0]        o_wdata,
    output logic                               o_mem_start,
    output logic                               o_mem_write,
    output logic [rv_bus_pkg::XLEN-1:0]        o_mem_addr,
    output logic [rv_bus_pkg::XLEN-1:0]        o_mem_wdata,
    input  wire                                i_mem_done,
    input  wire  [rv_bus_pkg::XLEN-1:0]        i_mem_rdata,
    output logic                               o_halted
);

    typedef enum logic [1:0] {st_run, st_mem, st_halt} state_t;

    state_t                              state;
    logic                                fire;
    logic                                equal;
    logic [rv_bus_pkg::XLEN-1:0]         op_b;
    logic [rv_bus_pkg::XLEN-1:0]         alu_res;
    logic                                load_pending;
    logic [rv_isa_pkg::REG_ADDR_W-1:0]   load_rd;

    // ------------------------------------------------------------------
    // ALU and branch resolution
    // ------------------------------------------------------------------

    assign op_b  = i_use_imm ? i_imm : i_rdata2;
    assign equal = (i_rdata1 == i_rdata2);

    always_comb
    begin
        case (i_alu_op)
            rv_isa_pkg::alu_sub: alu_res = i_rdata1 - op_b;
            rv_isa_pkg::alu_and: alu_res = i_rdata1 & op_b;
            rv_isa_pkg::alu_or:  alu_res = i_rdata1 | op_b;
            rv_isa_pkg::alu_xor: alu_res = i_rdata1 ^ op_b;
            rv_isa_pkg::alu_slt: alu_res = {31'b0, $signed(i_rdata1) < $signed(op_b)};
            default:             alu_res = i_rdata1 + op_b;
        endcase
    end

    assign fire       = (state == st_run) && i_instr_valid;
    assign o_take     = fire;
    assign o_target   = i_pc + i_imm;
    assign o_redirect = fire && (i_op == rv_isa_pkg::op_jal ||
                                 (i_op == rv_isa_pkg::op_beq && equal) ||
                                 (i_op == rv_isa_pkg::op_bne && !equal));

    assign o_mem_start = fire && (i_op == rv_isa_pkg::op_load ||
                                  i_op == rv_isa_pkg::op_store);
    assign o_mem_write = (i_op == rv_isa_pkg::op_store);
    assign o_mem_addr  = i_rdata1 + i_imm;
    assign o_mem_wdata = i_rdata2;

    // ------------------------------------------------------------------
    // write-back
    // ------------------------------------------------------------------

    // the buffer may already hold the next instruction while a load is out.
    assign o_rd = (state == st_mem) ? load_rd : i_rd;

    assign o_reg_write = (fire && (i_op == rv_isa_pkg::op_lui ||
                                   i_op == rv_isa_pkg::op_alu ||
                                   i_op == rv_isa_pkg::op_jal)) ||
                         (state == st_mem && i_mem_done && load_pending);

    always_comb
    begin
        if (state == st_mem)
            o_wdata = i_mem_rdata;
        else if (i_op == rv_isa_pkg::op_lui)
            o_wdata = i_imm;
        else if (i_op == rv_isa_pkg::op_jal)
            o_wdata = i_pc + 4; // link address.
        else
            o_wdata = alu_res;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            state <= st_run;
        else
        begin
            case (state)
                st_run:
                begin
                    if (o_mem_start)
                        state <= st_mem;
                    else if (fire && i_op == rv_isa_pkg::op_halt)
                        state <= st_halt;
                end
                st_mem:  if (i_mem_done) state <= st_run;
                default: state <= st_halt; // only reset leaves halt.
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (o_mem_start)
        begin
            load_pending <= !o_mem_write;
            load_rd      <= i_rd;
        end
    end

    assign o_halted = (state == st_halt);

    // the LSU only reports the end of an access that this unit started.
    assert property (@(posedge i_clk) disable iff (i_reset)
        i_mem_done |-> state == st_mem);

endmodule

/* hdl/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu
(
    input  wire                         i_clk,
    input  wire                         i_reset,
    input  wire                         i_start,
    input  wire                         i_write,
    input  wire  [rv_bus_pkg::XLEN-1:0] i_addr,
    input  wire  [rv_bus_pkg::XLEN-1:0] i_wdata,
    output logic                        o_done,
    output logic [rv_bus_pkg::XLEN-1:0] o_rdata,
    output logic                        o_req,
    output logic                        o_write,
    output logic [rv_bus_pkg::XLEN-1:0] o_addr,
    output logic [rv_bus_pkg::XLEN-1:0] o_wdata,
    input  wire                         i_ack,
    input  wire  [rv_bus_pkg::XLEN-1:0] i_rdata
);

    logic ack_wait; // req has dropped, waiting for ack to fall.

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_req    <= 1'b0;
            o_done   <= 1'b0;
            ack_wait <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            if (i_start)
                o_req <= 1'b1;
            else if (o_req && i_ack)
            begin
                o_req    <= 1'b0;
                ack_wait <= 1'b1;
            end
            else if (ack_wait && !i_ack)
            begin
                ack_wait <= 1'b0;
                o_done   <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_start)
        begin
            o_write <= i_write;
            o_addr  <= i_addr;
            o_wdata <= i_wdata;
        end
        if (o_req && i_ack)
            o_rdata <= i_rdata; // read data is only valid while ack is high.
    end

    assert property (@(posedge i_clk) disable iff (i_reset)
        o_req |-> o_addr[rv_bus_pkg::WORD_ALIGN_BITS-1:0] == '0);

endmodule

/* hdl/rv_bus_arbiter.sv */
`timescale 1ns/1ps

module rv_bus_arbiter
(
    input  wire                         i_clk,
    input  wire                         i_reset,
    // fetch side, read only.
    input  wire                         i_fetch_req,
    input  wire  [rv_bus_pkg::XLEN-1:0] i_fetch_addr,
    output logic                        o_fetch_ack,
    output logic [rv_bus_pkg::XLEN-1:0] o_fetch_rdata,
    // load/store side.
    input  wire                         i_lsu_req,
    input  wire                         i_lsu_write,
    input  wire  [rv_bus_pkg::XLEN-1:0] i_lsu_addr,
    input  wire  [rv_bus_pkg::XLEN-1:0] i_lsu_wdata,
    output logic                        o_lsu_ack,
    output logic [rv_bus_pkg::XLEN-1:0] o_lsu_rdata,
    // shared memory bus.
    output logic                        o_mem_req,
    output logic                        o_mem_write,
    output logic [rv_bus_pkg::XLEN-1:0] o_mem_addr,
    output logic [rv_bus_pkg::XLEN-1:0] o_mem_wdata,
    input  wire                         i_mem_ack,
    input  wire  [rv_bus_pkg::XLEN-1:0] i_mem_rdata
);

    rv_bus_pkg::requester_t grant;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            grant <= rv_bus_pkg::req_none;
        else if (!i_mem_ack)
        begin
            case (grant)
                rv_bus_pkg::req_none:
                begin
                    if (i_lsu_req) // data goes first.
                        grant <= rv_bus_pkg::req_data;
                    else if (i_fetch_req)
                        grant <= rv_bus_pkg::req_fetch;
                end
                rv_bus_pkg::req_fetch: if (!i_fetch_req) grant <= rv_bus_pkg::req_none;
                default:               if (!i_lsu_req) grant <= rv_bus_pkg::req_none;
            endcase
        end
    end

    always_comb
    begin
        o_mem_req   = 1'b0;
        o_mem_write = 1'b0;
        o_mem_addr  = i_fetch_addr;
        o_mem_wdata = i_lsu_wdata;
        if (grant == rv_bus_pkg::req_data)
        begin
            o_mem_req   = i_lsu_req;
            o_mem_write = i_lsu_write;
            o_mem_addr  = i_lsu_addr;
        end
        else if (grant == rv_bus_pkg::req_fetch)
            o_mem_req = i_fetch_req;
    end

    // ack goes back to the granted peer alone.
    assign o_fetch_ack   = (grant == rv_bus_pkg::req_fetch) && i_mem_ack;
    assign o_lsu_ack     = (grant == rv_bus_pkg::req_data) && i_mem_ack;
    assign o_fetch_rdata = i_mem_rdata;
    assign o_lsu_rdata   = i_mem_rdata;

    // a request on the shared bus stays up with its address until memory answers.
    assert property (@(posedge i_clk) disable iff (i_reset)
        (o_mem_req && !i_mem_ack) |=> o_mem_req && $stable(o_mem_addr));

endmodule

/* hdl/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top
#(
    parameter logic [rv_bus_pkg::XLEN-1:0] RESET_ADDR = '0
)
(
    input  wire                         i_clk,
    input  wire                         i_reset,
    output logic                        o_mem_req,
    output logic                        o_mem_write,
    output logic [rv_bus_pkg::XLEN-1:0] o_mem_addr,
    output logic [rv_bus_pkg::XLEN-1:0] o_mem_wdata,
    input  wire                         i_mem_ack,
    input  wire  [rv_bus_pkg::XLEN-1:0] i_mem_rdata,
    output logic                        o_halted
);

    logic [rv_bus_pkg::XLEN-1:0]        instr, pc, target, imm, rdata1, rdata2, wdata;
    logic                               instr_valid, take, redirect, use_imm, reg_write;
    logic [rv_isa_pkg::REG_ADDR_W-1:0]  rd, rs1, rs2, wb_rd;
    rv_isa_pkg::op_t                    op;
    rv_isa_pkg::alu_op_t                alu_op;

    logic                               fetch_req, fetch_ack, lsu_req, lsu_ack, lsu_write;
    logic [rv_bus_pkg::XLEN-1:0]        fetch_addr, fetch_rdata, lsu_addr, lsu_wdata;
    logic [rv_bus_pkg::XLEN-1:0]        lsu_rdata;
    logic                               mem_start, mem_write, mem_done;
    logic [rv_bus_pkg::XLEN-1:0]        mem_addr, mem_wdata, mem_rdata;

    rv_fetch #(.RESET_ADDR(RESET_ADDR)) u_fetch
    (
        .i_clk(i_clk), .i_reset(i_reset), .i_take(take), .i_redirect(redirect),
        .i_target(target), .i_halt(o_halted), .o_instr(instr), .o_pc(pc),
        .o_instr_valid(instr_valid), .o_req(fetch_req), .o_addr(fetch_addr),
        .i_ack(fetch_ack), .i_rdata(fetch_rdata)
    );

    rv_decode u_decode
    (
        .i_instr(instr), .o_op(op), .o_alu_op(alu_op), .o_rd(rd), .o_rs1(rs1),
        .o_rs2(rs2), .o_imm(imm), .o_use_imm(use_imm)
    );

    rv_regfile u_regfile
    (
        .i_clk(i_clk), .i_reset(i_reset), .i_rs1(rs1), .i_rs2(rs2), .i_rd(wb_rd),
        .i_write(reg_write), .i_wdata(wdata), .o_rdata1(rdata1), .o_rdata2(rdata2)
    );

    rv_execute u_execute
    (
        .i_clk(i_clk), .i_reset(i_reset), .i_instr_valid(instr_valid), .i_pc(pc),
        .i_op(op), .i_alu_op(alu_op), .i_rd(rd), .i_imm(imm), .i_use_imm(use_imm),
        .i_rdata1(rdata1), .i_rdata2(rdata2), .o_take(take), .o_redirect(redirect),
        .o_target(target), .o_reg_write(reg_write), .o_rd(wb_rd), .o_wdata(wdata),
        .o_mem_start(mem_start), .o_mem_write(mem_write), .o_mem_addr(mem_addr),
        .o_mem_wdata(mem_wdata), .i_mem_done(mem_done), .i_mem_rdata(mem_rdata),
        .o_halted(o_halted)
    );

    rv_lsu u_lsu
    (
        .i_clk(i_clk), .i_reset(i_reset), .i_start(mem_start), .i_write(mem_write),
        .i_addr(mem_addr), .i_wdata(mem_wdata), .o_done(mem_done), .o_rdata(mem_rdata),
        .o_req(lsu_req), .o_write(lsu_write), .o_addr(lsu_addr), .o_wdata(lsu_wdata),
        .i_ack(lsu_ack), .i_rdata(lsu_rdata)
    );

    rv_bus_arbiter u_arbiter
    (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_fetch_req(fetch_req), .i_fetch_addr(fetch_addr),
        .o_fetch_ack(fetch_ack), .o_fetch_rdata(fetch_rdata),
        .i_lsu_req(lsu_req), .i_lsu_write(lsu_write), .i_lsu_addr(lsu_addr),
        .i_lsu_wdata(lsu_wdata), .o_lsu_ack(lsu_ack), .o_lsu_rdata(lsu_rdata),
        .o_mem_req(o_mem_req), .o_mem_write(o_mem_write), .o_mem_addr(o_mem_addr),
        .o_mem_wdata(o_mem_wdata), .i_mem_ack(i_mem_ack), .i_mem_rdata(i_mem_rdata)
    );

endmodule

/* sim/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// x1 = 1443 and x2 = -28, the operand pair of the ALU rows.
task automatic emit_operands();
    emit(op_imm(1, 0, 1443));
    emit(op_imm(2, 0, -28));
endtask

task automatic build_table();
    // ------------------------------------------------------------------
    // register arithmetic
    // ------------------------------------------------------------------
    emit_operands();
    emit(op_reg(ADD_FN, 3, 1, 2));
    emit(store_word(3, 0, 'h80));
    emit(EBREAK);
    add_test("add", 'h80, 1443 + -28);

    emit_operands();
    emit(op_reg(SUB_FN, 3, 2, 1));
    emit(store_word(3, 0, 'h84));
    emit(EBREAK);
    add_test("sub", 'h84, -28 - 1443);

    emit_operands();
    emit(op_reg(SLT_FN, 4, 2, 1));   // signed compare gives 1.
    emit(op_reg(SLT_FN, 5, 1, 2));   // and 0 the other way round.
    emit(op_reg(ADD_FN, 6, 4, 4));
    emit(op_reg(ADD_FN, 6, 6, 5));
    emit(store_word(6, 0, 'h88));
    emit(EBREAK);
    add_test("slt", 'h88, 2);

    emit_operands();
    emit(op_reg(AND_FN, 3, 1, 2));
    emit(store_word(3, 0, 'h8c));
    emit(EBREAK);
    add_test("and", 'h8c, 1443 & -28);

    emit_operands();
    emit(op_reg(OR_FN, 3, 1, 2));
    emit(store_word(3, 0, 'h90));
    emit(EBREAK);
    add_test("or", 'h90, 1443 | -28);

    emit_operands();
    emit(op_reg(XOR_FN, 3, 1, 2));
    emit(store_word(3, 0, 'h94));
    emit(EBREAK);
    add_test("xor", 'h94, 1443 ^ -28);

    // ------------------------------------------------------------------
    // memory, control flow and x0
    // ------------------------------------------------------------------
    emit(op_imm(4, 0, 'h80));        // base register for the data words.
    emit(op_imm(1, 0, 1717));
    emit(store_word(1, 4, 24));
    emit(load_word(2, 4, 24));
    emit(op_imm(3, 2, 1));
    emit(store_word(3, 4, 28));
    emit(EBREAK);
    add_test("load_after_store", 'h9c, 1717 + 1);

    emit(op_imm(1, 0, 3));
    emit(op_imm(2, 0, 3));
    emit(branch(BEQ_F3, 1, 2, 8));   // taken.
    emit(op_imm(5, 0, 100));
    emit(op_imm(6, 0, 1));
    emit(branch(BNE_F3, 1, 2, 8));   // not taken.
    emit(op_imm(6, 6, 2));
    emit(branch(BNE_F3, 1, 0, 8));   // taken.
    emit(op_imm(6, 6, 4));
    emit(branch(BEQ_F3, 1, 0, 8));   // not taken.
    emit(op_imm(6, 6, 8));
    emit(op_reg(ADD_FN, 6, 6, 5));   // x5 must still be zero.
    emit(store_word(6, 0, 'ha0));
    emit(EBREAK);
    add_test("branch", 'ha0, 1 + 2 + 8);

    emit(op_imm(2, 0, 1));
    emit(jump_link(1, 8));           // sits at address 4.
    emit(op_imm(1, 0, 0));
    emit(store_word(1, 0, 'ha4));
    emit(EBREAK);
    add_test("jal_link", 'ha4, 4 + 4);

    emit(upper_imm(3, 20'habcde));
    emit(store_word(3, 0, 'ha8));
    emit(EBREAK);
    add_test("lui", 'ha8, {20'habcde, 12'h000});

    emit(op_imm(0, 0, 55));
    emit(op_imm(1, 0, 9));
    emit(op_reg(ADD_FN, 0, 1, 1));
    emit(store_word(0, 0, 'hac));
    emit(EBREAK);
    add_test("x0_and_halt", 'hac, 0);
endtask

`endif

/* sim/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int QUIET_CYCLES = 20;
    localparam int PROG_WORDS   = 16;
    localparam int MEM_WORDS    = 64;

    // {funct7, funct3} of the register operations.
    localparam logic [9:0] ADD_FN = {7'h00, 3'h0};
    localparam logic [9:0] SUB_FN = {7'h20, 3'h0};
    localparam logic [9:0] SLT_FN = {7'h00, 3'h2};
    localparam logic [9:0] XOR_FN = {7'h00, 3'h4};
    localparam logic [9:0] OR_FN  = {7'h00, 3'h6};
    localparam logic [9:0] AND_FN = {7'h00, 3'h7};
    localparam logic [2:0] BEQ_F3 = 3'h0;
    localparam logic [2:0] BNE_F3 = 3'h1;
    localparam logic [31:0] EBREAK = 32'h0010_0073;

    logic        i_clk = 1'b0;
    logic        i_reset = 1'b1;
    logic        i_mem_ack = 1'b0;
    logic [31:0] i_mem_rdata = '0;
    logic        o_mem_req;
    logic        o_mem_write;
    logic [31:0] o_mem_addr;
    logic [31:0] o_mem_wdata;
    logic        o_halted;

    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] prog_words [$];
    int          prog_start [$];
    int          prog_len [$];
    string       test_name [$];
    logic [31:0] test_addr [$];
    logic [31:0] test_word [$];
    int          row_start = 0;
    logic        table_ready = 1'b0;
    int          mismatches = 0;
    integer      seed = 70597;
    int          wait_cnt = -1;  // cycles left before ack, -1 when idle.
    int          drop_cnt = 0;
    logic        req_dropped = 1'b0;

    rv_core_top #(.RESET_ADDR(32'h0)) i_dut
    (
        .i_clk(i_clk), .i_reset(i_reset), .o_mem_req(o_mem_req),
        .o_mem_write(o_mem_write), .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata),
        .i_mem_ack(i_mem_ack), .i_mem_rdata(i_mem_rdata), .o_halted(o_halted)
    );

    initial
    begin
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // ------------------------------------------------------------------
    // instruction encoders and table building
    // ------------------------------------------------------------------

    function automatic logic [31:0] op_imm(logic [4:0] rd, logic [4:0] rs1, logic [31:0] imm);
        return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] op_reg(logic [9:0] fn, logic [4:0] rd, logic [4:0] rs1,
                                           logic [4:0] rs2);
        return {fn[9:3], rs2, rs1, fn[2:0], rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] load_word(logic [4:0] rd, logic [4:0] rs1,
                                              logic [31:0] imm);
        return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] store_word(logic [4:0] rs2, logic [4:0] rs1,
                                               logic [31:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                           logic [31:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jump_link(logic [4:0] rd, logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] upper_imm(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic emit(logic [31:0] word);
        prog_words.push_back(word);
    endtask

    task automatic add_test(string name, logic [31:0] addr, logic [31:0] word);
        test_name.push_back(name);
        test_addr.push_back(addr);
        test_word.push_back(word);
        prog_start.push_back(row_start);
        prog_len.push_back(prog_words.size() - row_start);
        row_start = prog_words.size();
    endtask

    `include "tb_programs.svh"

    // ------------------------------------------------------------------
    // failure reporting and checks
    // ------------------------------------------------------------------

    task automatic stop_with_failure(string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare_values(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected)
        begin
            mismatches++;
            stop_with_failure($sformatf("ERROR %s: expected %h, actual %h",
                                        name, expected, actual));
        end
    endtask

    // ------------------------------------------------------------------
    // memory model
    // ------------------------------------------------------------------

    task automatic serve_request();
        if (o_mem_addr >= MEM_WORDS * 4)
            stop_with_failure($sformatf("memory access at %h is outside the model", o_mem_addr));
        if (o_mem_write)
            mem[o_mem_addr >> 2] = o_mem_wdata;
        else
            i_mem_rdata = mem[o_mem_addr >> 2];
        drop_cnt  = $random(seed) & 1;
        i_mem_ack = 1'b1;
    endtask

    always @(negedge i_clk)
    begin
        if (i_reset)
        begin
            i_mem_ack   = 1'b0;
            wait_cnt    = -1;
            req_dropped = 1'b0;
        end
        else if (!i_mem_ack)
        begin
            if (wait_cnt >= 0 && !o_mem_req)
                stop_with_failure("memory request was withdrawn before it was acknowledged");
            if (o_mem_req && wait_cnt < 0)
                wait_cnt = $random(seed) & 3;
            if (wait_cnt == 0)
            begin
                serve_request();
                wait_cnt = -1;
            end
            else if (wait_cnt > 0)
                wait_cnt--;
        end
        else
        begin
            if (!o_mem_req)
                req_dropped = 1'b1;
            else if (req_dropped)
                stop_with_failure("memory request rose again while ack was still high");
            if (req_dropped && drop_cnt == 0)
            begin
                i_mem_ack   = 1'b0;
                req_dropped = 1'b0;
            end
            else if (req_dropped)
                drop_cnt--;
        end
    end

    task automatic load_program(int t);
        if (prog_len[t] > PROG_WORDS)
            stop_with_failure($sformatf("test %s has too many program words", test_name[t]));
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = 32'ha5a5_0000 ^ (i << 2);
        for (int i = 0; i < prog_len[t]; i++)
            mem[i] = prog_words[prog_start[t] + i];
    endtask

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------

    task automatic run_test(int t);
        int   new_reqs;
        logic prev_req;
        @(negedge i_clk);
        i_reset = 1'b1;
        load_program(t);
        repeat (RESET_CYCLES) @(negedge i_clk);
        compare_values({test_name[t], " reset state"}, 0, {o_mem_req, o_halted});
        i_reset = 1'b0;
        while (!o_halted)
            @(negedge i_clk);
        new_reqs = 0;
        prev_req = o_mem_req; // a fetch already in flight is allowed to finish.
        repeat (QUIET_CYCLES)
        begin
            @(negedge i_clk);
            if (o_mem_req && !prev_req)
                new_reqs++;
            prev_req = o_mem_req;
        end
        compare_values({test_name[t], " requests after halt"}, 0, new_reqs);
        compare_values({test_name[t], " halt held"}, 1, o_halted);
        compare_values(test_name[t], test_word[t], mem[test_addr[t] >> 2]);
    endtask

    initial
    begin
        build_table();
        table_ready = 1'b1;
        for (int t = 0; t < test_name.size(); t++)
            run_test(t);
        if (mismatches == 0)
        begin
            $display("Verification passed");
            $finish;
        end
        else
            stop_with_failure("some checks did not match");
    end

    // every row gets 12 cycles per program slot plus its reset and quiet windows.
    initial
    begin
        wait (table_ready);
        #(test_name.size() * (PROG_WORDS * 12 + RESET_CYCLES + QUIET_CYCLES + 1) * CLK_PERIOD);
        stop_with_failure("timeout: the core did not finish the test programs in time");
    end

endmodule

/* flist.f */
+incdir+sim
hdl/rv_isa_pkg.sv
hdl/rv_bus_pkg.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_fetch.sv
hdl/rv_execute.sv
hdl/rv_lsu.sv
hdl/rv_bus_arbiter.sv
hdl/rv_core_top.sv
sim/tb_rv_core.sv
